// File: design/ttc_consts.svh
// Widths, timer count, register kind codes and counter control bit positions
`ifndef TTC_CONSTS_SVH
`define TTC_CONSTS_SVH

// --------------------------------------------------
// Widths
// --------------------------------------------------
`define TTC_NUM_TIMERS   3    // Timers behind one APB port
`define TTC_ADDR_W       8    // APB address bits
`define TTC_DATA_W       32   // APB data bits
`define TTC_CNT_W        16   // Counter, interval and match width
`define TTC_INT_W        4    // Bit 0 interval/overflow, 1..3 match
`define TTC_PRESC_W      4    // Prescale exponent
`define TTC_NUM_KINDS    9    // Register kinds per timer

// --------------------------------------------------
// Register kinds, paddr[7:4]
// --------------------------------------------------
`define TTC_K_CLK_CTRL   0
`define TTC_K_CNTR_CTRL  1
`define TTC_K_COUNT      2    // Read only
`define TTC_K_INTERVAL   3
`define TTC_K_MATCH1     4
`define TTC_K_MATCH2     5
`define TTC_K_MATCH3     6
`define TTC_K_INT_STAT   7    // Read only, clears on read
`define TTC_K_INT_EN     8

// Counter control bits
`define TTC_CC_DISABLE   0
`define TTC_CC_INTERVAL  1
`define TTC_CC_DECR      2
`define TTC_CC_MATCH_EN  3
`define TTC_CC_RESET     4    // Write strobe only

`endif

// File: design/ttc_reg_pkg.sv
// APB bus types, register map types and APB phase enum
`include "ttc_consts.svh"

package ttc_reg_pkg;

   // --------------------------------------------------
   // APB bus
   // --------------------------------------------------
   typedef logic [`TTC_ADDR_W-1:0] apb_addr_t;   // paddr
   typedef logic [`TTC_DATA_W-1:0] apb_data_t;   // pwdata / prdata

   // APB transfer phase, one per pclk cycle
   typedef enum logic [1:0] {
      APB_IDLE,     // psel low
      APB_SETUP,    // psel high, penable low
      APB_ACCESS    // psel and penable high
   } apb_phase_e;

   // --------------------------------------------------
   // Register map
   // --------------------------------------------------

   // Kind field of paddr[7:4]
   typedef logic [3:0] reg_kind_t;

   // Timer number in paddr[3:2], 0 unmapped
   typedef logic [1:0] tmr_sel_t;

   // One write strobe per register kind
   typedef logic [`TTC_NUM_KINDS-1:0] kind_vec_t;

endpackage

// File: design/ttc_cnt_pkg.sv
// Counter, prescaler, control and interrupt types
`include "ttc_consts.svh"

package ttc_cnt_pkg;

   // Count, interval and match values
   typedef logic [`TTC_CNT_W-1:0] count_t;

   // --------------------------------------------------
   // Prescaler
   // --------------------------------------------------
   typedef logic [`TTC_PRESC_W-1:0] presc_exp_t;         // Exponent field

   // Prescale divider, wide enough for 2^(2^PRESC_W) cycles
   typedef logic [(1 << `TTC_PRESC_W)-1:0] presc_cnt_t;

   // Bit 0 prescale enable, bits 4:1 exponent
   typedef logic [`TTC_PRESC_W:0] clk_ctrl_t;

   // --------------------------------------------------
   // Control and interrupts
   // --------------------------------------------------

   // Disable, interval, decrement, match enable
   typedef logic [`TTC_CC_MATCH_EN:0] cntr_ctrl_t;

   // Status and enable, bit 0 wrap, bits 3:1 match 1..3
   typedef logic [`TTC_INT_W-1:0] int_vec_t;

endpackage

// File: design/ttc_reg_if.sv
// Register interface between the APB decoder and one timer
`timescale 1ns/1ns
`include "ttc_consts.svh"

interface ttc_reg_if;
   import ttc_reg_pkg::*;
   import ttc_cnt_pkg::*;

   // --------------------------------------------------
   // Decoder to timer
   // --------------------------------------------------
   kind_vec_t  wr_kind;     // One-hot write strobe, access cycle only
   count_t     wdata;       // Low half of pwdata
   logic       clr_int;     // Status read in progress

   // --------------------------------------------------
   // Timer readback
   // --------------------------------------------------
   clk_ctrl_t  clk_ctrl;
   cntr_ctrl_t cntr_ctrl;
   count_t     count;       // Live counter value
   count_t     interval;
   count_t     match1;
   count_t     match2;
   count_t     match3;
   int_vec_t   int_stat;
   int_vec_t   int_en;

   modport decoder (
      output wr_kind, wdata, clr_int,
      input  clk_ctrl, cntr_ctrl, count, interval,
      input  match1, match2, match3, int_stat, int_en
   );

   modport timer (
      input  wr_kind, wdata, clr_int,
      output clk_ctrl, cntr_ctrl, count, interval,
      output match1, match2, match3, int_stat, int_en
   );

endinterface

// File: design/ttc_apb_decode.sv
// APB slave, address decode into per-timer strobes and registered read mux
`timescale 1ns/1ns
`include "ttc_consts.svh"

module ttc_apb_decode (
   input  logic                  pclk,
   input  logic                  arst_n,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  ttc_reg_pkg::apb_addr_t paddr,
   input  ttc_reg_pkg::apb_data_t pwdata,
   output ttc_reg_pkg::apb_data_t prdata,
   ttc_reg_if.decoder            regs [`TTC_NUM_TIMERS]
);
   import ttc_reg_pkg::*;

   // Count and interrupt status cannot be written
   localparam kind_vec_t WR_MASK = ~((kind_vec_t'(1) << `TTC_K_COUNT) |
                                     (kind_vec_t'(1) << `TTC_K_INT_STAT));

   apb_phase_e phase;                      // Phase of this cycle
   apb_phase_e phase_q;                    // Phase of last cycle
   reg_kind_t  kind;
   tmr_sel_t   tmr;
   logic       mapped;                     // Valid kind and timer 1..3
   logic       acc_ok;                     // Access right after setup
   kind_vec_t  wr_onehot;
   apb_data_t  rd_tmr [`TTC_NUM_TIMERS];   // Readback per timer
   apb_data_t  rd_sel;
   logic [`TTC_NUM_TIMERS-1:0] tmr_hit;    // Timer strobed this cycle

   // --------------------------------------------------
   // Phase tracking and address split
   // --------------------------------------------------
   always_comb begin
      if (!psel)        phase = APB_IDLE;
      else if (penable) phase = APB_ACCESS;
      else              phase = APB_SETUP;
   end

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) phase_q <= APB_IDLE;
      else         phase_q <= phase;
   end

   assign kind   = paddr[7:4];
   assign tmr    = paddr[3:2];
   assign mapped = (kind <= reg_kind_t'(`TTC_K_INT_EN)) && (tmr != '0);
   assign acc_ok = (phase == APB_ACCESS) && (phase_q == APB_SETUP);

   // Strobe bit for the addressed kind, read-only kinds dropped
   assign wr_onehot = mapped ? ((kind_vec_t'(1) << kind) & WR_MASK) : '0;

   // --------------------------------------------------
   // Per-timer strobes and readback
   // --------------------------------------------------
   for (genvar t = 0; t < `TTC_NUM_TIMERS; t++) begin : g_tmr
      logic      sel;                      // This timer addressed
      kind_vec_t wr_vec;
      logic      clr;
      apb_data_t rd;

      assign sel    = mapped && (tmr == tmr_sel_t'(t + 1));
      assign wr_vec = (acc_ok && pwrite && sel) ? wr_onehot : '0;
      assign clr    = acc_ok && !pwrite && sel && (kind == reg_kind_t'(`TTC_K_INT_STAT));

      assign regs[t].wr_kind = wr_vec;
      assign regs[t].wdata   = pwdata[`TTC_CNT_W-1:0];   // Same data to all timers
      assign regs[t].clr_int = clr;
      assign tmr_hit[t]      = (|wr_vec) | clr;

      // Zero-extended readback mux
      always_comb begin
         case (kind)
            `TTC_K_CLK_CTRL:  rd = apb_data_t'(regs[t].clk_ctrl);
            `TTC_K_CNTR_CTRL: rd = apb_data_t'(regs[t].cntr_ctrl);
            `TTC_K_COUNT:     rd = apb_data_t'(regs[t].count);
            `TTC_K_INTERVAL:  rd = apb_data_t'(regs[t].interval);
            `TTC_K_MATCH1:    rd = apb_data_t'(regs[t].match1);
            `TTC_K_MATCH2:    rd = apb_data_t'(regs[t].match2);
            `TTC_K_MATCH3:    rd = apb_data_t'(regs[t].match3);
            `TTC_K_INT_STAT:  rd = apb_data_t'(regs[t].int_stat);
            `TTC_K_INT_EN:    rd = apb_data_t'(regs[t].int_en);
            default:          rd = '0;   // Unmapped kinds
         endcase
      end

      assign rd_tmr[t] = rd;
   end

   assign rd_sel = mapped ? rd_tmr[tmr - tmr_sel_t'(1)] : '0;

   // --------------------------------------------------
   // Read data, captured at end of setup
   // --------------------------------------------------
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         prdata <= '0;
      end else if (phase == APB_SETUP && !pwrite) begin
         prdata <= rd_sel;             // Held through access
      end else begin
         prdata <= '0;                 // Zero outside a read
      end
   end

   // --------------------------------------------------
   // Protocol checks
   // --------------------------------------------------
   a_penable_psel: assert property (@(posedge pclk) disable iff (!arst_n)
      penable |-> psel)
      else $error("penable high without psel");

   a_setup_access: assert property (@(posedge pclk) disable iff (!arst_n)
      phase == APB_SETUP |=> phase == APB_ACCESS)
      else $error("APB setup not followed by access");

   a_one_timer: assert property (@(posedge pclk) disable iff (!arst_n)
      $onehot0(tmr_hit))
      else $error("More than one timer strobed");

endmodule

// File: design/ttc_timer_counter.sv
// One timer: registers, prescaler, 16-bit up/down counter, match and interrupt logic
`timescale 1ns/1ns
`include "ttc_consts.svh"

module ttc_timer_counter (
   input  logic       pclk,
   input  logic       arst_n,
   ttc_reg_if.timer   regs,
   output logic       interrupt
);
   import ttc_cnt_pkg::*;

   localparam int         NUM_MATCH = `TTC_INT_W - 1;
   localparam presc_cnt_t PRESC_ALL = '1;

   clk_ctrl_t  clk_ctrl_q;
   cntr_ctrl_t cntr_ctrl_q;
   count_t     count_q;
   count_t     interval_q;
   count_t     match_q [NUM_MATCH];
   int_vec_t   int_stat_q;
   int_vec_t   int_en_q;
   int_vec_t   int_ev;                 // Status set requests
   presc_exp_t presc_exp;
   presc_cnt_t presc_q;
   presc_cnt_t presc_lim;
   logic       tick;                   // Prescaled tick
   logic       tick_q;                 // Counter advances one cycle later
   logic       running;
   logic       wr_cntr;
   logic       wrap;
   count_t     count_top;              // Wrap/reload point
   count_t     count_nxt;
   count_t     cnt_start;

   // --------------------------------------------------
   // Prescaler
   // --------------------------------------------------
   assign presc_exp = clk_ctrl_q[`TTC_PRESC_W:1];
   assign presc_lim = PRESC_ALL >> ~presc_exp;    // 2^(E+1) - 1
   assign tick      = !clk_ctrl_q[0] || (presc_q == presc_lim);

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         presc_q <= '0;
         tick_q  <= 1'b0;
      end else begin
         tick_q <= tick;
         if (tick || regs.wr_kind[`TTC_K_CLK_CTRL]) presc_q <= '0;   // Restart on reconfig
         else                                       presc_q <= presc_q + 1'b1;
      end
   end

   // --------------------------------------------------
   // Counter next value
   // --------------------------------------------------
   assign wr_cntr   = regs.wr_kind[`TTC_K_CNTR_CTRL];
   assign running   = tick_q && !cntr_ctrl_q[`TTC_CC_DISABLE];
   assign count_top = cntr_ctrl_q[`TTC_CC_INTERVAL] ? interval_q : '1;

   // Start value of a counter reset, from the control word being written
   assign cnt_start = !regs.wdata[`TTC_CC_DECR]    ? '0 :
                      regs.wdata[`TTC_CC_INTERVAL] ? interval_q : '1;

   always_comb begin
      wrap = 1'b0;
      if (cntr_ctrl_q[`TTC_CC_DECR]) begin
         if (count_q == '0) begin
            count_nxt = count_top;      // Reload
            wrap      = 1'b1;
         end else begin
            count_nxt = count_q - 1'b1;
         end
      end else if (count_q >= count_top) begin
         count_nxt = '0;                // Also catches interval lowered below count
         wrap      = 1'b1;
      end else begin
         count_nxt = count_q + 1'b1;
      end
   end

   // Interval/overflow and match events
   always_comb begin
      int_ev    = '0;
      int_ev[0] = running && wrap;
      for (int n = 0; n < NUM_MATCH; n++) begin
         int_ev[n+1] = running && cntr_ctrl_q[`TTC_CC_MATCH_EN] && (count_nxt == match_q[n]);
      end
   end

   // --------------------------------------------------
   // Registers
   // --------------------------------------------------
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         clk_ctrl_q  <= '0;
         cntr_ctrl_q <= cntr_ctrl_t'(1) << `TTC_CC_DISABLE;   // Stopped after reset
         count_q     <= '0;
         interval_q  <= '0;
         int_en_q    <= '0;
         int_stat_q  <= '0;
         for (int n = 0; n < NUM_MATCH; n++) begin
            match_q[n] <= '0;
         end
      end else begin
         if (regs.wr_kind[`TTC_K_CLK_CTRL]) clk_ctrl_q <= regs.wdata[`TTC_PRESC_W:0];
         if (wr_cntr)                       cntr_ctrl_q <= regs.wdata[`TTC_CC_MATCH_EN:0];
         if (regs.wr_kind[`TTC_K_INTERVAL]) interval_q <= regs.wdata;
         if (regs.wr_kind[`TTC_K_INT_EN])   int_en_q <= regs.wdata[`TTC_INT_W-1:0];
         for (int n = 0; n < NUM_MATCH; n++) begin
            if (regs.wr_kind[`TTC_K_MATCH1 + n]) match_q[n] <= regs.wdata;
         end

         // Software reset beats counting
         if (wr_cntr && regs.wdata[`TTC_CC_RESET]) count_q <= cnt_start;
         else if (running)                         count_q <= count_nxt;

         // Event in the clearing cycle survives
         int_stat_q <= (regs.clr_int ? '0 : int_stat_q) | int_ev;
      end
   end

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) interrupt <= 1'b0;
      else         interrupt <= |(int_stat_q & int_en_q);
   end

   // --------------------------------------------------
   // Readback
   // --------------------------------------------------
   assign regs.clk_ctrl  = clk_ctrl_q;
   assign regs.cntr_ctrl = cntr_ctrl_q;
   assign regs.count     = count_q;
   assign regs.interval  = interval_q;
   assign regs.match1    = match_q[0];
   assign regs.match2    = match_q[1];
   assign regs.match3    = match_q[2];
   assign regs.int_stat  = int_stat_q;
   assign regs.int_en    = int_en_q;

   // --------------------------------------------------
   // Counter checks
   // --------------------------------------------------
   a_in_interval: assert property (@(posedge pclk) disable iff (!arst_n)
      running && cntr_ctrl_q[`TTC_CC_INTERVAL] && (count_q <= interval_q) &&
      !wr_cntr && !regs.wr_kind[`TTC_K_INTERVAL] |=> count_q <= interval_q)
      else $error("Count left the interval range");

   a_hold_disabled: assert property (@(posedge pclk) disable iff (!arst_n)
      cntr_ctrl_q[`TTC_CC_DISABLE] && !wr_cntr |=> $stable(count_q))
      else $error("Disabled counter changed");

endmodule

// File: design/ttc_lite.sv
// Triple timer counter top level: APB decoder and three timers
`timescale 1ns/1ns
`include "ttc_consts.svh"

module ttc_lite (
   input  logic                        pclk,
   input  logic                        arst_n,
   input  logic                        psel,
   input  logic                        penable,
   input  logic                        pwrite,      // 1 write, 0 read
   input  ttc_reg_pkg::apb_addr_t      paddr,
   input  ttc_reg_pkg::apb_data_t      pwdata,
   output ttc_reg_pkg::apb_data_t      prdata,
   output logic [`TTC_NUM_TIMERS-1:0]  interrupt    // One line per timer
);

   // --------------------------------------------------
   // Decoder to timer links
   // --------------------------------------------------
   ttc_reg_if reg_if [`TTC_NUM_TIMERS] ();

   // APB slave and register decode
   ttc_apb_decode apb_decode_inst (
      .pclk    (pclk),
      .arst_n  (arst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .regs    (reg_if)
   );

   // --------------------------------------------------
   // Timers 1..3 at timer numbers 1..3 of the map
   // --------------------------------------------------
   for (genvar i = 0; i < `TTC_NUM_TIMERS; i++) begin : g_timer
      ttc_timer_counter timer_inst (
         .pclk      (pclk),
         .arst_n    (arst_n),
         .regs      (reg_if[i]),
         .interrupt (interrupt[i])
      );
   end

endmodule

// File: dv/ttc_lite_tb.sv
// Testbench for the triple timer counter with clock, reset, APB tasks, stimulus, checks, watchdog
`timescale 1ns/1ns
`include "ttc_consts.svh"

module ttc_lite_tb;

   localparam int CLK_PERIOD = 10;
   localparam int RST_CYCLES = 5;
   // Cycle budget per test
   localparam int T_RESET = 100;
   localparam int T_REGS  = 400;
   localparam int T_COUNT = 150;
   localparam int T_IRQ   = 250;
   localparam int T_MATCH = 250;
   localparam int T_PRESC = 700;
   localparam int BUDGET  = (RST_CYCLES + T_RESET + T_REGS + T_COUNT + T_IRQ + T_MATCH +
                             T_PRESC) * 12 / 10;

   logic        pclk;
   logic        arst_n;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic [2:0]  interrupt;
   logic [31:0] rnd_state;
   int          cycle_cnt;

   ttc_lite ttc_lite_inst (
      .pclk      (pclk),
      .arst_n    (arst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .interrupt (interrupt)
   );

   // --------------------------------------------------
   // Clock, cycle count, watchdog
   // --------------------------------------------------
   initial begin
      pclk = 1'b0;
      forever #(CLK_PERIOD / 2) pclk = ~pclk;
   end

   always @(posedge pclk) cycle_cnt <= cycle_cnt + 1;

   initial begin
      #(BUDGET * CLK_PERIOD);
      fail_stop("Timeout, the run took longer than its cycle budget");
   end

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------
   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act)
      else fail_stop($sformatf("ERR %s expected %h actual %h", name, exp, act));
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rnd_state = xorshift32(rnd_state);
      return rnd_state;
   endfunction

   // Kind in bits 7:4, timer in bits 3:2
   function automatic logic [7:0] reg_addr(input int kind, input int tmr);
      return {kind[3:0], tmr[1:0], 2'b00};
   endfunction

   // Readable width of each register kind
   function automatic logic [31:0] reg_mask(input int kind);
      case (kind)
         `TTC_K_CLK_CTRL:  return 32'h1F;
         `TTC_K_CNTR_CTRL: return 32'h0F;
         `TTC_K_INT_STAT:  return 32'h0F;
         `TTC_K_INT_EN:    return 32'h0F;
         default:          return 32'hFFFF;
      endcase
   endfunction

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge pclk);
      psel    <= 1'b1;          // Setup
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge pclk);
      penable <= 1'b1;          // Access
      @(posedge pclk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      @(posedge pclk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge pclk);
      penable <= 1'b1;
      @(negedge pclk);
      data = prdata;            // Mid access cycle
      @(posedge pclk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   // Polls at the falling edge until the line reaches the level
   task automatic wait_irq(input int idx, input logic level, input int limit);
      int  n;
      logic seen;
      seen = 1'b0;
      n    = 0;
      while (!seen && n < limit) begin
         @(negedge pclk);
         seen = (interrupt[idx] == level);
         n++;
      end
      assert (seen)
      else fail_stop($sformatf("Interrupt %0d did not reach %0b in %0d cycles", idx, level, limit));
   endtask

   // Stopped, counter at zero, no prescale, nothing enabled, status cleared
   task automatic quiet_timer(input int tmr);
      logic [31:0] rd;
      apb_write(reg_addr(`TTC_K_CNTR_CTRL, tmr), 32'h11);
      apb_write(reg_addr(`TTC_K_CLK_CTRL, tmr), 32'h0);
      apb_write(reg_addr(`TTC_K_INT_EN, tmr), 32'h0);
      apb_write(reg_addr(`TTC_K_MATCH1, tmr), 32'hFFFF);
      apb_write(reg_addr(`TTC_K_MATCH2, tmr), 32'hFFFF);
      apb_write(reg_addr(`TTC_K_MATCH3, tmr), 32'hFFFF);
      apb_read(reg_addr(`TTC_K_INT_STAT, tmr), rd);
   endtask

   // prdata is zero outside a transfer
   a_prdata_idle: assert property (@(posedge pclk) disable iff (!arst_n)
      !psel |-> prdata == '0)
      else fail_stop("prdata was not zero while the bus was idle");

   // --------------------------------------------------
   // Tests
   // --------------------------------------------------
   initial begin
      logic [31:0] rd;
      logic [31:0] rd2;
      logic [31:0] v;
      logic [31:0] exp_iv [1:3];
      int          k;
      int          t1;
      int          t2;
      int          kinds [7];

      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      arst_n    = 1'b0;
      cycle_cnt = 0;
      rnd_state = 32'd32;
      kinds     = '{0, 1, 3, 4, 5, 6, 8};
      repeat (RST_CYCLES) @(posedge pclk);
      arst_n <= 1'b1;

      // 1. Reset values
      for (int t = 1; t <= 3; t++) begin
         for (int kd = 0; kd <= `TTC_K_INT_EN; kd++) begin
            apb_read(reg_addr(kd, t), rd);
            check_eq($sformatf("reset t%0d k%0d", t, kd), (kd == `TTC_K_CNTR_CTRL) ? 1 : 0, rd);
         end
      end
      check_eq("reset irq", 0, interrupt);

      // 2. Register readback, masked to width
      for (int t = 1; t <= 3; t++) begin
         foreach (kinds[i]) begin
            v = next_rand();
            if (kinds[i] == `TTC_K_CNTR_CTRL) v[`TTC_CC_DISABLE] = 1'b1;   // Keep it stopped
            apb_write(reg_addr(kinds[i], t), v);
            apb_read(reg_addr(kinds[i], t), rd);
            check_eq($sformatf("rdback t%0d k%0d", t, kinds[i]), v & reg_mask(kinds[i]), rd);
            if (kinds[i] == `TTC_K_INTERVAL) exp_iv[t] = v & 32'hFFFF;
         end
      end
      apb_write(reg_addr(`TTC_K_INTERVAL, 0), 32'h1234);   // Timer 0 unmapped
      apb_write(reg_addr(11, 1), 32'h5678);                // Interval kind with bit 7 set
      for (int t = 1; t <= 3; t++) begin
         apb_read(reg_addr(`TTC_K_INTERVAL, t), rd);
         check_eq($sformatf("unmapped wr t%0d", t), exp_iv[t], rd);
      end
      apb_read(reg_addr(`TTC_K_INTERVAL, 0), rd);
      check_eq("unmapped rd t0", 0, rd);
      for (int kd = 9; kd < 16; kd++) begin
         apb_read(reg_addr(kd, 2), rd);
         check_eq($sformatf("unmapped rd k%0d", kd), 0, rd);
      end
      for (int t = 1; t <= 3; t++) quiet_timer(t);

      // 3. Counting, prescale off, overflow mode
      apb_write(reg_addr(`TTC_K_CNTR_CTRL, 1), 32'h10);
      for (int r = 0; r < 4; r++) begin
         k = (next_rand() % 20) + 1;
         apb_read(reg_addr(`TTC_K_COUNT, 1), rd);
         repeat (k) @(posedge pclk);
         apb_read(reg_addr(`TTC_K_COUNT, 1), rd2);
         check_eq("count delta", (rd + k + 3) & 32'hFFFF, rd2);   // Reads start k+3 apart
      end
      apb_write(reg_addr(`TTC_K_CNTR_CTRL, 1), 32'h01);
      apb_read(reg_addr(`TTC_K_COUNT, 1), rd);
      repeat (7) @(posedge pclk);
      apb_read(reg_addr(`TTC_K_COUNT, 1), rd2);
      check_eq("count hold", rd, rd2);

      // 4. Interval interrupt, up then down
      apb_write(reg_addr(`TTC_K_INTERVAL, 2), 32'd20);
      apb_write(reg_addr(`TTC_K_INT_EN, 2), 32'h1);
      for (int dn = 0; dn < 2; dn++) begin
         apb_write(reg_addr(`TTC_K_CNTR_CTRL, 2), dn ? 32'h16 : 32'h12);
         wait_irq(1, 1'b1, 60);
         apb_write(reg_addr(`TTC_K_CNTR_CTRL, 2), 32'h03);   // Stop before clearing
         apb_read(reg_addr(`TTC_K_INT_STAT, 2), rd);
         check_eq($sformatf("ivl stat dn%0d", dn), 1, rd);
         apb_read(reg_addr(`TTC_K_INT_STAT, 2), rd);
         check_eq($sformatf("ivl clear dn%0d", dn), 0, rd);
      end

      // 5. Match 2 inside the interval, then masked
      apb_write(reg_addr(`TTC_K_INTERVAL, 3), 32'd40);
      apb_write(reg_addr(`TTC_K_MATCH2, 3), 32'd15);
      apb_write(reg_addr(`TTC_K_INT_EN, 3), 32'h4);
      apb_write(reg_addr(`TTC_K_CNTR_CTRL, 3), 32'h1A);
      wait_irq(2, 1'b1, 60);
      apb_write(reg_addr(`TTC_K_CNTR_CTRL, 3), 32'h0B);
      apb_read(reg_addr(`TTC_K_INT_STAT, 3), rd);
      check_eq("match stat", 1, rd[2]);
      apb_write(reg_addr(`TTC_K_INT_EN, 3), 32'h0);
      apb_write(reg_addr(`TTC_K_CNTR_CTRL, 3), 32'h1A);
      repeat (30) begin
         @(negedge pclk);
         check_eq("masked irq", 0, interrupt[2]);
      end
      apb_write(reg_addr(`TTC_K_CNTR_CTRL, 3), 32'h0B);
      apb_read(reg_addr(`TTC_K_INT_STAT, 3), rd);
      check_eq("masked stat", 1, rd[2]);

      // 6. Prescaler, period (I+1)*2^(E+1)
      apb_write(reg_addr(`TTC_K_INTERVAL, 1), 32'd7);
      apb_write(reg_addr(`TTC_K_INT_EN, 1), 32'h1);
      for (int e = 0; e < 3; e++) begin
         apb_write(reg_addr(`TTC_K_CNTR_CTRL, 1), 32'h03);
         apb_read(reg_addr(`TTC_K_INT_STAT, 1), rd);
         apb_write(reg_addr(`TTC_K_CLK_CTRL, 1), (e << 1) | 1);
         apb_write(reg_addr(`TTC_K_CNTR_CTRL, 1), 32'h12);
         wait_irq(0, 1'b1, 100);
         t1 = cycle_cnt;
         apb_read(reg_addr(`TTC_K_INT_STAT, 1), rd);     // Clear while running
         wait_irq(0, 1'b0, 10);
         wait_irq(0, 1'b1, 100);
         t2 = cycle_cnt;
         check_eq($sformatf("presc period e%0d", e), 8 << (e + 1), t2 - t1);
      end
      apb_write(reg_addr(`TTC_K_CNTR_CTRL, 1), 32'h03);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// File: tb.f
+incdir+design
design/ttc_reg_pkg.sv
design/ttc_cnt_pkg.sv
design/ttc_reg_if.sv
design/ttc_apb_decode.sv
design/ttc_timer_counter.sv
design/ttc_lite.sv
dv/ttc_lite_tb.sv

// File: Bender.yml
package:
  name: ttc_lite

sources:
  - include_dirs:
      - design
    files:
      - design/ttc_reg_pkg.sv
      - design/ttc_cnt_pkg.sv
      - design/ttc_reg_if.sv
      - design/ttc_apb_decode.sv
      - design/ttc_timer_counter.sv
      - design/ttc_lite.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - dv/ttc_lite_tb.sv
